// File: Makefile
TOOL       = verilator
TOP        = tb_regmst_root_map
FILELIST   = compile.f
BUILD      = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert -j 0 -Mdir $(BUILD)
LINT_FLAGS = --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: compile.f
+incdir+hdl
hdl/regmap_pkg.sv
hdl/apb_pkg.sv
hdl/field_reg.sv
hdl/ext_bridge.sv
hdl/regmap_decoder.sv
hdl/apb_mst_fsm.sv
hdl/regfile.sv
hdl/regmst_root_map.sv
verification/regmap_sva.sv
verification/regmap_checker.sv
verification/tb_regmst_root_map.sv

// File: hdl/apb_mst_fsm.sv
`timescale 1ns/1ps
`include "regmap_cfg.svh"

module apb_mst_fsm (
	input logic pclk_i,
	input logic rst_n_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [`REGMAP_ADDR_W-1:0] paddr_i,
	input logic [`REGMAP_DATA_W-1:0] pwdata_i,
	input logic none_sel_i,
	input logic int_ack_i,
	input logic [`REGMAP_DATA_W-1:0] int_rd_data_i,
	input logic ext_ack_i,
	input logic [`REGMAP_DATA_W-1:0] ext_rd_data_i,
	output logic pready_o,
	output logic [`REGMAP_DATA_W-1:0] prdata_o,
	output logic req_vld_o,
	output logic wr_en_o,
	output logic rd_en_o,
	output logic [`REGMAP_ADDR_W-1:0] addr_o,
	output logic [`REGMAP_DATA_W-1:0] wr_data_o
);

	import apb_pkg::*;

	apb_state_t state;
	apb_state_t state_nxt;
	logic start;
	logic resp_vld;

	// Setup phase seen while idle
	assign start = (state == IDLE) && psel_i && !penable_i;
	// Unmapped access answers itself once in WAIT
	assign resp_vld = int_ack_i || ext_ack_i || none_sel_i;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = REQ;
				end
			end
			REQ: state_nxt = WAIT;
			WAIT: begin
				// Only the external side can hold us here
				if (resp_vld) begin
					state_nxt = DONE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge pclk_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Direction latched on setup, held through the transfer
	always_ff @(posedge pclk_i) begin
		if (!rst_n_i) begin
			wr_en_o <= 1'b0;
			rd_en_o <= 1'b0;
		end else if (start) begin
			wr_en_o <= pwrite_i;
			rd_en_o <= !pwrite_i;
		end
	end

	// Address and write data
	always_ff @(posedge pclk_i) begin
		if (start) begin
			addr_o <= paddr_i;
			wr_data_o <= pwdata_i;
		end
	end

	// Response word, presented in DONE
	always_ff @(posedge pclk_i) begin
		if (!rst_n_i) begin
			prdata_o <= '0;
		end else if (state == WAIT) begin
			if (int_ack_i) begin
				prdata_o <= int_rd_data_i;
			end else if (ext_ack_i) begin
				prdata_o <= ext_rd_data_i;
			end else if (none_sel_i) begin
				prdata_o <= '0;
			end
		end
	end

	assign req_vld_o = (state == REQ);
	assign pready_o = (state == DONE);

endmodule

// File: hdl/apb_pkg.sv
package apb_pkg;

	// Progress of one APB transfer at the slave port
	// REQ lasts a single cycle and carries the request strobe
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		REQ = 2'd1,
		WAIT = 2'd2,
		DONE = 2'd3
	} apb_state_t;

endpackage

// File: hdl/ext_bridge.sv
`timescale 1ns/1ps
`include "regmap_cfg.svh"

module ext_bridge (
	input logic pclk_i,
	input logic rst_n_i,
	input logic ext_ack_vld_i,
	input logic [`REGMAP_DATA_W-1:0] ext_rd_data_i,
	output logic ack_o,
	output logic [`REGMAP_DATA_W-1:0] rd_data_o
);

	// One register stage on the reply strobe
	always_ff @(posedge pclk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= ext_ack_vld_i;
		end
	end

	// Capture read data together with its strobe
	// Held afterwards, the FSM samples it with ack_o
	always_ff @(posedge pclk_i) begin
		if (ext_ack_vld_i) begin
			rd_data_o <= ext_rd_data_i;
		end
	end

endmodule

// File: hdl/field_reg.sv
`timescale 1ns/1ps

module field_reg #(
	parameter type field_t = logic,
	parameter field_t RESET = '0,
	parameter int ALIAS_NUM = 1
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic [ALIAS_NUM-1:0] sw_wr_i,
	input field_t sw_wr_data_i,
	input field_t hw_value_i,
	input logic hw_pulse_i,
	output field_t value_o
);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			value_o <= RESET;
		end else if (|sw_wr_i) begin
			// Any alias write, software beats hardware
			value_o <= sw_wr_data_i;
		end else if (hw_pulse_i) begin
			// Hardware update only when software is quiet
			value_o <= hw_value_i;
		end
	end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps
`include "regmap_cfg.svh"

module regfile (
	input logic pclk_i,
	input logic rst_n_i,
	input logic req_i,
	input logic wr_en_i,
	input logic rd_en_i,
	input regmap_pkg::reg_sel_t reg_sel_i,
	input logic [`REGMAP_DATA_W-1:0] wr_data_i,
	input regmap_pkg::f1_t f1_next_value_i,
	input logic f1_pulse_i,
	input regmap_pkg::f2_t f2_next_value_i,
	input logic f2_pulse_i,
	input regmap_pkg::shared_t shared_f_next_value_i,
	input logic shared_f_pulse_i,
	input regmap_pkg::x_t x0_next_value_i,
	input logic x0_pulse_i,
	input regmap_pkg::x_t x1_next_value_i,
	input logic x1_pulse_i,
	input regmap_pkg::x_t x2_next_value_i,
	input logic x2_pulse_i,
	input regmap_pkg::x_t x3_next_value_i,
	input logic x3_pulse_i,
	output logic ack_o,
	output logic [`REGMAP_DATA_W-1:0] rd_data_o,
	output regmap_pkg::f1_t f1_curr_value_o,
	output regmap_pkg::f2_t f2_curr_value_o,
	output regmap_pkg::shared_t shared_f_curr_value_o,
	output regmap_pkg::x_t x0_curr_value_o,
	output regmap_pkg::x_t x1_curr_value_o,
	output regmap_pkg::x_t x2_curr_value_o,
	output regmap_pkg::x_t x3_curr_value_o
);

	import regmap_pkg::*;

	reg_sel_t wr_sel;
	logic [`REGMAP_DATA_W-1:0] rd_word;

	// Per-register write strobe, only during the request cycle
	assign wr_sel = reg_sel_i & {`REG_NUM{req_i & wr_en_i}};

	// reg1
	field_reg #(.field_t(f1_t), .RESET('0), .ALIAS_NUM(1)) u_f1 (
		.clk_i(pclk_i), .rst_n_i(rst_n_i), .sw_wr_i(wr_sel[IDX_REG1]),
		.sw_wr_data_i(wr_data_i[`F1_LSB +: $bits(f1_t)]),
		.hw_value_i(f1_next_value_i), .hw_pulse_i(f1_pulse_i), .value_o(f1_curr_value_o)
	);
	field_reg #(.field_t(f2_t), .RESET(f2_t'(`F2_RESET)), .ALIAS_NUM(1)) u_f2 (
		.clk_i(pclk_i), .rst_n_i(rst_n_i), .sw_wr_i(wr_sel[IDX_REG1]),
		.sw_wr_data_i(wr_data_i[`F2_LSB +: $bits(f2_t)]),
		.hw_value_i(f2_next_value_i), .hw_pulse_i(f2_pulse_i), .value_o(f2_curr_value_o)
	);

	// One storage, written through either alias address
	field_reg #(.field_t(shared_t), .RESET('0), .ALIAS_NUM(2)) u_shared_f (
		.clk_i(pclk_i), .rst_n_i(rst_n_i),
		.sw_wr_i({wr_sel[IDX_SHARED_B], wr_sel[IDX_SHARED_A]}),
		.sw_wr_data_i(wr_data_i[`SHARED_LSB +: $bits(shared_t)]),
		.hw_value_i(shared_f_next_value_i), .hw_pulse_i(shared_f_pulse_i),
		.value_o(shared_f_curr_value_o)
	);

	// reg_array entries
	field_reg #(.field_t(x_t), .RESET('0), .ALIAS_NUM(1)) u_x0 (
		.clk_i(pclk_i), .rst_n_i(rst_n_i), .sw_wr_i(wr_sel[IDX_ARRAY0]),
		.sw_wr_data_i(wr_data_i[`X_LSB +: $bits(x_t)]),
		.hw_value_i(x0_next_value_i), .hw_pulse_i(x0_pulse_i), .value_o(x0_curr_value_o)
	);
	field_reg #(.field_t(x_t), .RESET('0), .ALIAS_NUM(1)) u_x1 (
		.clk_i(pclk_i), .rst_n_i(rst_n_i), .sw_wr_i(wr_sel[IDX_ARRAY1]),
		.sw_wr_data_i(wr_data_i[`X_LSB +: $bits(x_t)]),
		.hw_value_i(x1_next_value_i), .hw_pulse_i(x1_pulse_i), .value_o(x1_curr_value_o)
	);
	field_reg #(.field_t(x_t), .RESET('0), .ALIAS_NUM(1)) u_x2 (
		.clk_i(pclk_i), .rst_n_i(rst_n_i), .sw_wr_i(wr_sel[IDX_ARRAY2]),
		.sw_wr_data_i(wr_data_i[`X_LSB +: $bits(x_t)]),
		.hw_value_i(x2_next_value_i), .hw_pulse_i(x2_pulse_i), .value_o(x2_curr_value_o)
	);
	field_reg #(.field_t(x_t), .RESET('0), .ALIAS_NUM(1)) u_x3 (
		.clk_i(pclk_i), .rst_n_i(rst_n_i), .sw_wr_i(wr_sel[IDX_ARRAY3]),
		.sw_wr_data_i(wr_data_i[`X_LSB +: $bits(x_t)]),
		.hw_value_i(x3_next_value_i), .hw_pulse_i(x3_pulse_i), .value_o(x3_curr_value_o)
	);

	// Read word, unused bits stay zero, select is one-hot
	always_comb begin
		rd_word = '0;
		if (reg_sel_i[IDX_REG1]) begin
			rd_word[`F1_LSB +: $bits(f1_t)] = f1_curr_value_o;
			rd_word[`F2_LSB +: $bits(f2_t)] = f2_curr_value_o;
		end
		// Both aliases show the same bits
		if (reg_sel_i[IDX_SHARED_A] || reg_sel_i[IDX_SHARED_B]) begin
			rd_word[`SHARED_LSB +: $bits(shared_t)] = shared_f_curr_value_o;
		end
		if (reg_sel_i[IDX_ARRAY0]) begin
			rd_word[`X_LSB +: $bits(x_t)] = x0_curr_value_o;
		end
		if (reg_sel_i[IDX_ARRAY1]) begin
			rd_word[`X_LSB +: $bits(x_t)] = x1_curr_value_o;
		end
		if (reg_sel_i[IDX_ARRAY2]) begin
			rd_word[`X_LSB +: $bits(x_t)] = x2_curr_value_o;
		end
		if (reg_sel_i[IDX_ARRAY3]) begin
			rd_word[`X_LSB +: $bits(x_t)] = x3_curr_value_o;
		end
	end

	// Ack one cycle after the request, reads and writes alike
	always_ff @(posedge pclk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req_i;
		end
	end

	always_ff @(posedge pclk_i) begin
		if (req_i && rd_en_i) begin
			rd_data_o <= rd_word;
		end
	end

endmodule

// File: hdl/regmap_cfg.svh
`ifndef REGMAP_CFG_SVH
`define REGMAP_CFG_SVH

// APB address and data widths
`define REGMAP_ADDR_W 16
`define REGMAP_DATA_W 32

// Internal register file addresses
`define ADDR_SHARED_A 16'h0118
`define ADDR_SHARED_B 16'h011c
`define ADDR_REG1 16'h0200
`define ADDR_ARRAY0 16'h0300
`define ADDR_ARRAY1 16'h0304
`define ADDR_ARRAY2 16'h0308
`define ADDR_ARRAY3 16'h030c

// Window of the external register module
`define ADDR_EXT0 16'h000c
`define ADDR_EXT1 16'h0010
`define ADDR_EXT2 16'h0014
`define ADDR_EXT3 16'h010c
`define ADDR_EXT4 16'h0110
`define ADDR_EXT5 16'h0114

// Field placement in the data word
`define F1_LSB 0
`define F2_LSB 8
`define SHARED_LSB 12
`define X_LSB 0

// f2 comes out of reset non-zero
`define F2_RESET 8'h7b
// Two shared aliases, reg1 and four array entries
`define REG_NUM 7

`endif

// File: hdl/regmap_decoder.sv
`timescale 1ns/1ps
`include "regmap_cfg.svh"

module regmap_decoder (
	input logic [`REGMAP_ADDR_W-1:0] addr_i,
	output logic int_sel_o,
	output logic ext_sel_o,
	output logic none_sel_o,
	output regmap_pkg::reg_sel_t reg_sel_o
);

	import regmap_pkg::*;

	// Single address table, target class and one-hot register select
	always_comb begin
		reg_sel_o = '0;
		ext_sel_o = 1'b0;
		case (addr_i)
			`ADDR_SHARED_A: reg_sel_o[IDX_SHARED_A] = 1'b1;
			`ADDR_SHARED_B: reg_sel_o[IDX_SHARED_B] = 1'b1;
			`ADDR_REG1: reg_sel_o[IDX_REG1] = 1'b1;
			`ADDR_ARRAY0: reg_sel_o[IDX_ARRAY0] = 1'b1;
			`ADDR_ARRAY1: reg_sel_o[IDX_ARRAY1] = 1'b1;
			`ADDR_ARRAY2: reg_sel_o[IDX_ARRAY2] = 1'b1;
			`ADDR_ARRAY3: reg_sel_o[IDX_ARRAY3] = 1'b1;
			// External module window
			`ADDR_EXT0, `ADDR_EXT1, `ADDR_EXT2,
			`ADDR_EXT3, `ADDR_EXT4, `ADDR_EXT5: ext_sel_o = 1'b1;
			default: ext_sel_o = 1'b0;
		endcase
	end

	assign int_sel_o = |reg_sel_o;
	// Neither target, FSM completes it with zero data
	assign none_sel_o = !int_sel_o && !ext_sel_o;

endmodule

// File: hdl/regmap_pkg.sv
`include "regmap_cfg.svh"

package regmap_pkg;

	// Field value types, one per hardware-visible field
	typedef logic [0:0] f1_t;
	typedef logic [7:0] f2_t;
	typedef logic [1:0] shared_t;
	typedef logic [0:0] x_t;

	// One-hot select over the internal registers
	typedef logic [`REG_NUM-1:0] reg_sel_t;

	// Bit positions inside reg_sel_t
	typedef enum int {
		IDX_SHARED_A = 0,
		IDX_SHARED_B = 1,
		IDX_REG1 = 2,
		IDX_ARRAY0 = 3,
		IDX_ARRAY1 = 4,
		IDX_ARRAY2 = 5,
		IDX_ARRAY3 = 6
	} reg_idx_e;

endpackage

// File: hdl/regmst_root_map.sv
`timescale 1ns/1ps
`include "regmap_cfg.svh"

module regmst_root_map (
	input logic pclk_i,
	input logic rst_n_i,
	// APB slave port
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [`REGMAP_ADDR_W-1:0] paddr_i,
	input logic [`REGMAP_DATA_W-1:0] pwdata_i,
	output logic pready_o,
	output logic [`REGMAP_DATA_W-1:0] prdata_o,
	// External register module, req/ack strobes
	output logic ext_req_vld_o,
	input logic ext_ack_vld_i,
	output logic ext_wr_en_o,
	output logic ext_rd_en_o,
	output logic [`REGMAP_ADDR_W-1:0] ext_addr_o,
	output logic [`REGMAP_DATA_W-1:0] ext_wr_data_o,
	input logic [`REGMAP_DATA_W-1:0] ext_rd_data_i,
	// Hardware side of the internal fields
	input regmap_pkg::f1_t f1_next_value_i,
	input logic f1_pulse_i,
	output regmap_pkg::f1_t f1_curr_value_o,
	input regmap_pkg::f2_t f2_next_value_i,
	input logic f2_pulse_i,
	output regmap_pkg::f2_t f2_curr_value_o,
	input regmap_pkg::shared_t shared_f_next_value_i,
	input logic shared_f_pulse_i,
	output regmap_pkg::shared_t shared_f_curr_value_o,
	input regmap_pkg::x_t x0_next_value_i,
	input logic x0_pulse_i,
	output regmap_pkg::x_t x0_curr_value_o,
	input regmap_pkg::x_t x1_next_value_i,
	input logic x1_pulse_i,
	output regmap_pkg::x_t x1_curr_value_o,
	input regmap_pkg::x_t x2_next_value_i,
	input logic x2_pulse_i,
	output regmap_pkg::x_t x2_curr_value_o,
	input regmap_pkg::x_t x3_next_value_i,
	input logic x3_pulse_i,
	output regmap_pkg::x_t x3_curr_value_o
);

	import regmap_pkg::*;

	// Command from the FSM
	logic req_vld;
	logic wr_en;
	logic rd_en;
	logic [`REGMAP_ADDR_W-1:0] addr;
	logic [`REGMAP_DATA_W-1:0] wr_data;
	// Decode result
	logic int_sel;
	logic ext_sel;
	logic none_sel;
	reg_sel_t reg_sel;
	// Target responses
	logic int_req;
	logic int_ack;
	logic [`REGMAP_DATA_W-1:0] int_rd_data;
	logic ext_ack;
	logic [`REGMAP_DATA_W-1:0] ext_rd_data;

	// Request strobe steered by target class
	assign int_req = req_vld & int_sel;
	assign ext_req_vld_o = req_vld & ext_sel;
	assign ext_wr_en_o = wr_en;
	assign ext_rd_en_o = rd_en;
	assign ext_addr_o = addr;
	assign ext_wr_data_o = wr_data;

	apb_mst_fsm u_fsm (
		.pclk_i(pclk_i), .rst_n_i(rst_n_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.none_sel_i(none_sel),
		.int_ack_i(int_ack), .int_rd_data_i(int_rd_data),
		.ext_ack_i(ext_ack), .ext_rd_data_i(ext_rd_data),
		.pready_o(pready_o), .prdata_o(prdata_o),
		.req_vld_o(req_vld), .wr_en_o(wr_en), .rd_en_o(rd_en),
		.addr_o(addr), .wr_data_o(wr_data)
	);

	regmap_decoder u_decoder (
		.addr_i(addr),
		.int_sel_o(int_sel),
		.ext_sel_o(ext_sel),
		.none_sel_o(none_sel),
		.reg_sel_o(reg_sel)
	);

	// Field ports share their names with the top level
	regfile u_regfile (
		.pclk_i(pclk_i), .rst_n_i(rst_n_i),
		.req_i(int_req), .wr_en_i(wr_en), .rd_en_i(rd_en),
		.reg_sel_i(reg_sel), .wr_data_i(wr_data),
		.ack_o(int_ack), .rd_data_o(int_rd_data),
		.*
	);

	ext_bridge u_ext_bridge (
		.pclk_i(pclk_i), .rst_n_i(rst_n_i),
		.ext_ack_vld_i(ext_ack_vld_i), .ext_rd_data_i(ext_rd_data_i),
		.ack_o(ext_ack), .rd_data_o(ext_rd_data)
	);

endmodule

// File: verification/regmap_checker.sv
`timescale 1ns/1ps
`include "regmap_cfg.svh"

module regmap_checker (
	input logic clk_i,
	input logic rst_n_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [`REGMAP_ADDR_W-1:0] paddr_i,
	input logic [`REGMAP_DATA_W-1:0] pwdata_i,
	input logic pready_i,
	input logic [`REGMAP_DATA_W-1:0] prdata_i,
	input logic ext_req_vld_i,
	input logic ext_wr_en_i,
	input logic ext_rd_en_i,
	input logic [`REGMAP_ADDR_W-1:0] ext_addr_i,
	input logic [`REGMAP_DATA_W-1:0] ext_wr_data_i,
	input regmap_pkg::f1_t f1_next_i,
	input logic f1_pulse_i,
	input regmap_pkg::f1_t f1_curr_i,
	input regmap_pkg::f2_t f2_next_i,
	input logic f2_pulse_i,
	input regmap_pkg::f2_t f2_curr_i,
	input regmap_pkg::shared_t sh_next_i,
	input logic sh_pulse_i,
	input regmap_pkg::shared_t sh_curr_i,
	input logic [3:0] x_next_i,
	input logic [3:0] x_pulse_i,
	input logic [3:0] x_curr_i,
	output int err_cnt_o
);

	import regmap_pkg::*;

	// Reference state of the map
	f1_t f1_m;
	f2_t f2_m;
	shared_t sh_m;
	logic [3:0] x_m;
	logic [`REGMAP_DATA_W-1:0] ext_mem [logic [`REGMAP_ADDR_W-1:0]];
	// External requests seen in the open transfer
	int ext_req_cnt;

	// Power-up content of the external module, never-written words
	function automatic logic [31:0] ext_fill(input logic [15:0] a);
		return {~a, a ^ 16'h9c35};
	endfunction

	function automatic int array_index(input logic [15:0] a);
		case (a)
			`ADDR_ARRAY0: return 0;
			`ADDR_ARRAY1: return 1;
			`ADDR_ARRAY2: return 2;
			`ADDR_ARRAY3: return 3;
			default: return -1;
		endcase
	endfunction

	function automatic logic is_ext(input logic [15:0] a);
		return a inside {`ADDR_EXT0, `ADDR_EXT1, `ADDR_EXT2, `ADDR_EXT3, `ADDR_EXT4, `ADDR_EXT5};
	endfunction

	function automatic logic is_shared(input logic [15:0] a);
		return (a == `ADDR_SHARED_A) || (a == `ADDR_SHARED_B);
	endfunction

	// Read word the map should return, zeros in unused bits
	function automatic logic [31:0] expected_read(input logic [15:0] a);
		logic [31:0] w;
		int k;
		w = '0;
		k = array_index(a);
		if (a == `ADDR_REG1) begin
			w[`F1_LSB +: $bits(f1_t)] = f1_m;
			w[`F2_LSB +: $bits(f2_t)] = f2_m;
		end else if (is_shared(a)) begin
			w[`SHARED_LSB +: $bits(shared_t)] = sh_m;
		end else if (k >= 0) begin
			w[`X_LSB] = x_m[k];
		end else if (is_ext(a)) begin
			w = ext_mem.exists(a) ? ext_mem[a] : ext_fill(a);
		end
		return w;
	endfunction

	task automatic apply_write(input logic [15:0] a, input logic [31:0] d);
		int k;
		k = array_index(a);
		if (a == `ADDR_REG1) begin
			f1_m = d[`F1_LSB +: $bits(f1_t)];
			f2_m = d[`F2_LSB +: $bits(f2_t)];
		end else if (is_shared(a)) begin
			// Either alias lands in the one field
			sh_m = d[`SHARED_LSB +: $bits(shared_t)];
		end else if (k >= 0) begin
			x_m[k] = d[`X_LSB];
		end else if (is_ext(a)) begin
			ext_mem[a] = d;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
			err_cnt_o++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		err_cnt_o++;
	endtask

	// Mid-cycle sampling, all inputs settled
	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			f1_m = '0;
			f2_m = `F2_RESET;
			sh_m = '0;
			x_m = '0;
			ext_req_cnt = 0;
			err_cnt_o = 0;
		end else begin
			// Hardware view between transfers
			if (!psel_i) begin
				check_value("f1_curr_value_o", 32'(f1_m), 32'(f1_curr_i));
				check_value("f2_curr_value_o", 32'(f2_m), 32'(f2_curr_i));
				check_value("shared_f_curr_value_o", 32'(sh_m), 32'(sh_curr_i));
				for (int k = 0; k < 4; k++) begin
					check_value($sformatf("x%0d_curr_value_o", k), 32'(x_m[k]), 32'(x_curr_i[k]));
				end
				if (pready_i) begin
					report_error("PREADY raised with no transfer in progress");
				end
				if (ext_req_vld_i) begin
					report_error("external request raised with no transfer in progress");
				end
			end
			// Hardware pulses land at the next edge
			if (f1_pulse_i) begin
				f1_m = f1_next_i;
			end
			if (f2_pulse_i) begin
				f2_m = f2_next_i;
			end
			if (sh_pulse_i) begin
				sh_m = sh_next_i;
			end
			for (int k = 0; k < 4; k++) begin
				if (x_pulse_i[k]) begin
					x_m[k] = x_next_i[k];
				end
			end
			// Forwarded command must mirror the APB access
			if (ext_req_vld_i) begin
				ext_req_cnt++;
				if (!is_ext(paddr_i)) begin
					report_error($sformatf("external request for address %h", paddr_i));
				end
				check_value("ext_addr_o", 32'(paddr_i), 32'(ext_addr_i));
				check_value("ext_wr_en_o", 32'(pwrite_i), 32'(ext_wr_en_i));
				check_value("ext_rd_en_o", 32'(!pwrite_i), 32'(ext_rd_en_i));
				if (pwrite_i) begin
					check_value("ext_wr_data_o", pwdata_i, ext_wr_data_i);
				end
			end
			// Completed transfer
			if (psel_i && penable_i && pready_i) begin
				if (pwrite_i) begin
					apply_write(paddr_i, pwdata_i);
				end else begin
					check_value("prdata_o", expected_read(paddr_i), prdata_i);
				end
				if (ext_req_cnt != (is_ext(paddr_i) ? 1 : 0)) begin
					report_error($sformatf("%0d external requests for address %h",
						ext_req_cnt, paddr_i));
				end
				ext_req_cnt = 0;
			end
		end
	end

endmodule

// File: verification/regmap_sva.sv
`timescale 1ns/1ps

module regmap_sva (
	input logic pclk_i,
	input logic rst_n_i,
	input logic psel_i,
	input logic penable_i,
	input apb_pkg::apb_state_t state_i,
	input logic req_vld_i,
	input logic pready_i
);

	import apb_pkg::*;

	// Open transfer from the request up to DONE
	logic busy;

	always_ff @(posedge pclk_i) begin
		if (!rst_n_i) begin
			busy <= 1'b0;
		end else if (req_vld_i) begin
			busy <= 1'b1;
		end else if (state_i == DONE) begin
			busy <= 1'b0;
		end
	end

	// PREADY is a single-cycle strobe
	pready_single: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
		pready_i |=> !pready_i)
		else $error("PREADY held for more than one cycle");

	// Request strobe only in the first access-phase cycle
	req_in_req_state: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
		req_vld_i |-> psel_i && penable_i && $past(psel_i && !penable_i))
		else $error("req_vld raised outside the first access-phase cycle");

	// One request per transfer
	single_req: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
		req_vld_i |-> !busy)
		else $error("second request before the transfer completed");

endmodule

bind apb_mst_fsm regmap_sva u_sva (
	.pclk_i(pclk_i), .rst_n_i(rst_n_i), .psel_i(psel_i), .penable_i(penable_i),
	.state_i(state), .req_vld_i(req_vld_o), .pready_i(pready_o)
);

// File: verification/tb_regmst_root_map.sv
`timescale 1ns/1ps
`include "regmap_cfg.svh"

module tb_regmst_root_map;

	import regmap_pkg::*;

	localparam int NUM_XFERS = 400;
	// Setup, REQ, up to five WAIT, DONE and up to two idle cycles
	localparam int CYCLES_PER_XFER = 10;
	localparam int TIMEOUT_CYCLES = NUM_XFERS * CYCLES_PER_XFER + 2000;
	// Internal addresses first, then the external window
	localparam logic [15:0] MAP_ADDR [13] = '{
		`ADDR_SHARED_A, `ADDR_SHARED_B, `ADDR_REG1, `ADDR_ARRAY0, `ADDR_ARRAY1,
		`ADDR_ARRAY2, `ADDR_ARRAY3, `ADDR_EXT0, `ADDR_EXT1, `ADDR_EXT2,
		`ADDR_EXT3, `ADDR_EXT4, `ADDR_EXT5
	};

	integer seed = 32'h74d54591;
	logic pclk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic pready;
	logic [31:0] prdata;
	logic ext_req_vld;
	logic ext_ack_vld;
	logic ext_wr_en;
	logic ext_rd_en;
	logic [15:0] ext_addr;
	logic [31:0] ext_wr_data;
	logic [31:0] ext_rd_data;
	f1_t f1_next;
	f1_t f1_curr;
	logic f1_pulse;
	f2_t f2_next;
	f2_t f2_curr;
	logic f2_pulse;
	shared_t sh_next;
	shared_t sh_curr;
	logic sh_pulse;
	logic [3:0] x_next;
	logic [3:0] x_curr;
	logic [3:0] x_pulse;
	int err_cnt;
	int xfer_cnt;
	int cycle_cnt;
	// Content of the external register module
	logic [31:0] ext_mem [logic [15:0]];

	regmst_root_map i_dut (
		.pclk_i(pclk), .rst_n_i(rst_n),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .pready_o(pready), .prdata_o(prdata),
		.ext_req_vld_o(ext_req_vld), .ext_ack_vld_i(ext_ack_vld),
		.ext_wr_en_o(ext_wr_en), .ext_rd_en_o(ext_rd_en), .ext_addr_o(ext_addr),
		.ext_wr_data_o(ext_wr_data), .ext_rd_data_i(ext_rd_data),
		.f1_next_value_i(f1_next), .f1_pulse_i(f1_pulse), .f1_curr_value_o(f1_curr),
		.f2_next_value_i(f2_next), .f2_pulse_i(f2_pulse), .f2_curr_value_o(f2_curr),
		.shared_f_next_value_i(sh_next), .shared_f_pulse_i(sh_pulse),
		.shared_f_curr_value_o(sh_curr),
		.x0_next_value_i(x_next[0]), .x0_pulse_i(x_pulse[0]), .x0_curr_value_o(x_curr[0]),
		.x1_next_value_i(x_next[1]), .x1_pulse_i(x_pulse[1]), .x1_curr_value_o(x_curr[1]),
		.x2_next_value_i(x_next[2]), .x2_pulse_i(x_pulse[2]), .x2_curr_value_o(x_curr[2]),
		.x3_next_value_i(x_next[3]), .x3_pulse_i(x_pulse[3]), .x3_curr_value_o(x_curr[3])
	);

	regmap_checker i_checker (
		.clk_i(pclk), .rst_n_i(rst_n),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .pready_i(pready), .prdata_i(prdata),
		.ext_req_vld_i(ext_req_vld), .ext_wr_en_i(ext_wr_en), .ext_rd_en_i(ext_rd_en),
		.ext_addr_i(ext_addr), .ext_wr_data_i(ext_wr_data),
		.f1_next_i(f1_next), .f1_pulse_i(f1_pulse), .f1_curr_i(f1_curr),
		.f2_next_i(f2_next), .f2_pulse_i(f2_pulse), .f2_curr_i(f2_curr),
		.sh_next_i(sh_next), .sh_pulse_i(sh_pulse), .sh_curr_i(sh_curr),
		.x_next_i(x_next), .x_pulse_i(x_pulse), .x_curr_i(x_curr),
		.err_cnt_o(err_cnt)
	);

	// 8 ns clock
	initial begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;
	end

	// Power-up content, differs for every address bit
	function automatic logic [31:0] ext_fill(input logic [15:0] a);
		return {~a, a ^ 16'h9c35};
	endfunction

	// Mapped addresses mostly, random words otherwise
	function automatic logic [15:0] pick_addr(input logic [31:0] r);
		if (r[3:0] < 4'd13) begin
			return MAP_ADDR[r[3:0]];
		end
		return r[31:16];
	endfunction

	// Full APB transfer, enters and leaves one tick after a rising edge
	task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(posedge pclk);
		#1;
		penable = 1'b1;
		@(negedge pclk);
		while (!pready) begin
			@(negedge pclk);
		end
		@(posedge pclk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		xfer_cnt++;
	endtask

	// Idle bus, random hardware updates
	task automatic idle_cycles(input int n);
		logic [31:0] r;
		logic [31:0] v;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			v = $random(seed);
			// Roughly one pulse in eight per field
			f1_pulse = &r[2:0];
			f2_pulse = &r[5:3];
			sh_pulse = &r[8:6];
			for (int k = 0; k < 4; k++) begin
				x_pulse[k] = &r[9 + 3 * k +: 3];
			end
			f1_next = v[0];
			f2_next = v[8:1];
			sh_next = v[10:9];
			x_next = v[14:11];
			@(posedge pclk);
			#1;
		end
		f1_pulse = 1'b0;
		f2_pulse = 1'b0;
		sh_pulse = 1'b0;
		x_pulse = '0;
	endtask

	// External register module, answers after 0 to 3 extra cycles
	initial begin : ext_model
		logic [31:0] r;
		int delay;
		ext_ack_vld = 1'b0;
		ext_rd_data = '0;
		forever begin
			@(negedge pclk);
			if (ext_req_vld) begin
				r = $random(seed);
				delay = int'(r[1:0]);
				if (ext_wr_en) begin
					ext_mem[ext_addr] = ext_wr_data;
				end
				@(posedge pclk);
				repeat (delay) @(posedge pclk);
				#1;
				ext_ack_vld = 1'b1;
				ext_rd_data = ext_mem.exists(ext_addr) ? ext_mem[ext_addr] : ext_fill(ext_addr);
				@(posedge pclk);
				#1;
				ext_ack_vld = 1'b0;
			end
		end
	end

	// Run limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge pclk);
			cycle_cnt++;
		end
		$display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] wd;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		f1_next = '0;
		f1_pulse = 1'b0;
		f2_next = '0;
		f2_pulse = 1'b0;
		sh_next = '0;
		sh_pulse = 1'b0;
		x_next = '0;
		x_pulse = '0;
		xfer_cnt = 0;
		repeat (4) @(posedge pclk);
		#1;
		rst_n = 1'b1;
		// Reset values, every mapped address once
		for (int i = 0; i < 13; i++) begin
			apb_xfer(1'b0, MAP_ADDR[i], '0);
		end
		// Alias pair, written through one address and read through the other
		apb_xfer(1'b1, `ADDR_SHARED_A, 32'h0000_1000);
		apb_xfer(1'b0, `ADDR_SHARED_B, '0);
		apb_xfer(1'b1, `ADDR_SHARED_B, 32'hffff_efff);
		apb_xfer(1'b0, `ADDR_SHARED_A, '0);
		idle_cycles(2);
		// Random mix of targets and directions
		for (int i = 0; i < NUM_XFERS; i++) begin
			r = $random(seed);
			idle_cycles(1 + int'(r[0]));
			r = $random(seed);
			wd = $random(seed);
			apb_xfer(r[4], pick_addr(r), wd);
		end
		idle_cycles(2);
		$display("Summary: %0d transfers, %0d errors", xfer_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
